//--- apu_seq/apu_frame_div.sv
module apu_frame_div #(
	parameter int frame_bit = 12
) (
	input  logic                     clkin_a,
	input  logic                     rst_n,
	input  logic                     run,
	input  dmg_clk_pkg::div_t        count,
	output dmg_clk_pkg::frame_tick_t ticks
);

	logic       bit_q;
	logic       bit_fall;
	logic [2:0] step_q;

	dmg_clk_pkg::frame_tick_t ticks_q;

	assign bit_fall = bit_q && !count[frame_bit];

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			bit_q <= 1'b0;
		end else begin
			bit_q <= count[frame_bit];
		end
	end

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			step_q <= 3'd0;
		end else if (!run) begin
			step_q <= 3'd0;
		end else if (bit_fall) begin
			step_q <= step_q + 3'd1;
		end
	end

	// ticks are decoded from the step being taken.
	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			ticks_q <= '0;
		end else begin
			ticks_q.tick_512 <= run && bit_fall;
			ticks_q.tick_256 <= run && bit_fall && !step_q[0];
			ticks_q.tick_128 <= run && bit_fall && (step_q[1:0] == 2'b10); // steps 2 and 6.
		end
	end

	assign ticks = ticks_q;

endmodule

//--- common/dmg_clk_pkg.sv
package dmg_clk_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [15:0] div_t;

	// one machine cycle is four master clocks.
	typedef enum logic [1:0] {
		phase_a,
		phase_b,
		phase_c,
		phase_d
	} phase_t;

	typedef enum logic [1:0] {
		rs_hold,
		rs_wait_phase,
		rs_run
	} reset_state_t;

	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  wr;
		logic  rd;
	} bus_req_t;

	// one-cycle pulses to the audio frame sequencer.
	typedef struct packed {
		logic tick_512;
		logic tick_256;
		logic tick_128;
	} frame_tick_t;

	// timer clock levels.
	typedef struct packed {
		logic hz_16384;
		logic hz_65536;
		logic hz_262144;
	} div_taps_t;

	localparam addr_t addr_div  = 16'hff04; // divider.
	localparam addr_t addr_lcdc = 16'hff40; // lcd control.
	localparam addr_t addr_test = 16'hff60; // test register.

endpackage

//--- div/div_counter.sv
module div_counter (
	input  logic              clkin_a,
	input  logic              rst_n,
	input  logic              run,
	input  logic              clear,
	input  logic              fast,
	output dmg_clk_pkg::div_t count,
	output dmg_clk_pkg::div_taps_t taps
);

	// bit n toggles at master / 2^(n+1).
	localparam int tap_16384  = 7;
	localparam int tap_65536  = 5;
	localparam int tap_262144 = 3;

	localparam dmg_clk_pkg::div_t step_normal = 16'd1;
	localparam dmg_clk_pkg::div_t step_fast   = 16'd256;

	dmg_clk_pkg::div_t count_q;
	dmg_clk_pkg::div_t step;

	assign step = fast ? step_fast : step_normal; // test mode skips the low byte.

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
		end else if (clear) begin
			count_q <= '0; // write to ff04.
		end else if (run) begin
			count_q <= count_q + step;
		end
	end

	assign count = count_q;

	assign taps.hz_16384  = count_q[tap_16384];
	assign taps.hz_65536  = count_q[tap_65536];
	assign taps.hz_262144 = count_q[tap_262144];

endmodule

//--- rtl/clk_regs.sv
module clk_regs (
	input  logic                  clkin_a,
	input  logic                  rst_n,
	input  logic                  run,
	input  dmg_clk_pkg::bus_req_t bus,
	input  dmg_clk_pkg::div_t     count,
	output dmg_clk_pkg::data_t    rdata,
	output logic                  div_clear,
	output logic                  lcd_on,
	output logic                  test_fast
);

	logic wr_en;
	logic rd_en;

	dmg_clk_pkg::data_t lcdc_q;
	dmg_clk_pkg::data_t test_q;
	dmg_clk_pkg::data_t rd_mux;

	assign wr_en = run && bus.wr;
	assign rd_en = run && bus.rd;

	// the write edge itself clears the divider.
	assign div_clear = wr_en && (bus.addr == dmg_clk_pkg::addr_div);

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			lcdc_q <= '0;
			test_q <= '0;
		end else if (wr_en) begin
			if (bus.addr == dmg_clk_pkg::addr_lcdc) lcdc_q <= bus.wdata;
			if (bus.addr == dmg_clk_pkg::addr_test) test_q <= bus.wdata;
		end
	end

	assign lcd_on    = lcdc_q[7];
	assign test_fast = test_q[1];

	always_comb begin
		case (bus.addr)
			dmg_clk_pkg::addr_div:  rd_mux = count[15:8]; // upper byte only.
			dmg_clk_pkg::addr_lcdc: rd_mux = lcdc_q;
			dmg_clk_pkg::addr_test: rd_mux = test_q;
			default:                rd_mux = 8'hff; // unmapped.
		endcase
	end

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (rd_en) begin
			rdata <= rd_mux; // held until next read.
		end
	end

endmodule

//--- rtl/clocks_reset.sv
module clocks_reset #(
	parameter int frame_bit   = 12,
	parameter int sync_stages = 2
) (
	input  logic                     clkin_a,
	input  logic                     rst_n,
	input  logic                     ext_reset,
	input  dmg_clk_pkg::bus_req_t    bus,
	output dmg_clk_pkg::data_t       rdata,
	output logic                     sys_rst_n,
	output logic                     video_rst_n,
	output logic                     phi,
	output logic                     cpu_ce,
	output logic                     cpu_rd_sync,
	output dmg_clk_pkg::div_taps_t   taps,
	output dmg_clk_pkg::frame_tick_t ticks
);

	logic phase_last;
	logic div_clear;
	logic lcd_on;
	logic test_fast;

	dmg_clk_pkg::div_t count;

	phase_gen u_phase_gen (
		.clkin_a     (clkin_a),
		.rst_n       (rst_n),
		.rd          (bus.rd),
		.phi         (phi),
		.cpu_ce      (cpu_ce),
		.cpu_rd_sync (cpu_rd_sync),
		.phase_last  (phase_last)
	);

	reset_seq #(
		.sync_stages (sync_stages)
	) u_reset_seq (
		.clkin_a     (clkin_a),
		.rst_n       (rst_n),
		.ext_reset   (ext_reset),
		.phase_last  (phase_last),
		.lcd_on      (lcd_on),
		.sys_rst_n   (sys_rst_n),
		.video_rst_n (video_rst_n)
	);

	div_counter u_div_counter (
		.clkin_a (clkin_a),
		.rst_n   (rst_n),
		.run     (sys_rst_n),
		.clear   (div_clear),
		.fast    (test_fast),
		.count   (count),
		.taps    (taps)
	);

	apu_frame_div #(
		.frame_bit (frame_bit)
	) u_apu_frame_div (
		.clkin_a (clkin_a),
		.rst_n   (rst_n),
		.run     (sys_rst_n),
		.count   (count),
		.ticks   (ticks)
	);

	clk_regs u_clk_regs (
		.clkin_a   (clkin_a),
		.rst_n     (rst_n),
		.run       (sys_rst_n),
		.bus       (bus),
		.count     (count),
		.rdata     (rdata),
		.div_clear (div_clear),
		.lcd_on    (lcd_on),
		.test_fast (test_fast)
	);

endmodule

//--- rtl/phase_gen.sv
module phase_gen (
	input  logic clkin_a,
	input  logic rst_n,
	input  logic rd,
	output logic phi,
	output logic cpu_ce,
	output logic cpu_rd_sync,
	output logic phase_last
);

	dmg_clk_pkg::phase_t phase_q;
	dmg_clk_pkg::phase_t phase_next;

	always_comb begin
		case (phase_q)
			dmg_clk_pkg::phase_a: phase_next = dmg_clk_pkg::phase_b;
			dmg_clk_pkg::phase_b: phase_next = dmg_clk_pkg::phase_c;
			dmg_clk_pkg::phase_c: phase_next = dmg_clk_pkg::phase_d;
			dmg_clk_pkg::phase_d: phase_next = dmg_clk_pkg::phase_a;
			default:              phase_next = dmg_clk_pkg::phase_a;
		endcase
	end

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= dmg_clk_pkg::phase_a;
		end else begin
			phase_q <= phase_next;
		end
	end

	// phi is the first half of the machine cycle.
	assign phi = (phase_q == dmg_clk_pkg::phase_a) || (phase_q == dmg_clk_pkg::phase_b);

	assign phase_last = (phase_q == dmg_clk_pkg::phase_d);
	assign cpu_ce     = phase_last; // cpu advances once per machine cycle.

	// strobe used by the cpu to latch external read data.
	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			cpu_rd_sync <= 1'b0;
		end else begin
			cpu_rd_sync <= rd && phi;
		end
	end

endmodule

//--- rtl/reset_seq.sv
module reset_seq #(
	parameter int sync_stages = 2
) (
	input  logic clkin_a,
	input  logic rst_n,
	input  logic ext_reset,
	input  logic phase_last,
	input  logic lcd_on,
	output logic sys_rst_n,
	output logic video_rst_n
);

	logic [sync_stages-1:0] sync_q;
	logic                   ext_sync;

	dmg_clk_pkg::reset_state_t state_q;
	dmg_clk_pkg::reset_state_t state_next;

	// chain starts asserted.
	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '1;
		end else begin
			sync_q[0] <= ext_reset;
			for (int i = 1; i < sync_stages; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	assign ext_sync = sync_q[sync_stages-1];

	always_comb begin
		state_next = state_q;
		case (state_q)
			dmg_clk_pkg::rs_hold: begin
				if (!ext_sync) begin
					// release straight away when already at the boundary.
					state_next = phase_last ? dmg_clk_pkg::rs_run : dmg_clk_pkg::rs_wait_phase;
				end
			end
			dmg_clk_pkg::rs_wait_phase: begin
				if (ext_sync) begin
					state_next = dmg_clk_pkg::rs_hold;
				end else if (phase_last) begin
					state_next = dmg_clk_pkg::rs_run;
				end
			end
			dmg_clk_pkg::rs_run: begin
				if (ext_sync) begin
					state_next = dmg_clk_pkg::rs_hold;
				end
			end
			default: state_next = dmg_clk_pkg::rs_hold;
		endcase
	end

	always_ff @(posedge clkin_a or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= dmg_clk_pkg::rs_hold;
			video_rst_n <= 1'b0;
		end else begin
			state_q     <= state_next;
			video_rst_n <= sys_rst_n && lcd_on; // lcd off keeps video in reset.
		end
	end

	assign sys_rst_n = (state_q == dmg_clk_pkg::rs_run);

endmodule

//--- tb.f
common/dmg_clk_pkg.sv
rtl/phase_gen.sv
rtl/reset_seq.sv
div/div_counter.sv
apu_seq/apu_frame_div.sv
rtl/clk_regs.sv
rtl/clocks_reset.sv
testbench/tb_clocks_reset.sv

//--- testbench/clocks_reset_input.txt
# op addr data wait expected (addr data expected in hex and wait in decimal)
# W is a write and R a read with check and WAIT idles and TICKS counts frame ticks
R ff40 00 2 00
W ff40 91 4 00
R ff40 00 2 91
W ff60 58 3 00
R ff60 00 2 58
W ff60 00 2 00
R 1234 00 2 ff
R ff05 00 2 ff
W ff04 00 40 00
R ff04 00 2 00
W ff04 00 300 00
R ff04 00 2 01
W ff04 00 600 00
R ff04 00 2 02
W ff04 00 1300 00
R ff04 00 2 05
WAIT 0 0 20 00
W ff04 00 100 00
R ff04 00 2 00
W ff60 02 2 00
R ff60 00 2 02
W ff04 00 4 00
TICKS 0 0 2048 40
W ff60 00 2 00
R ff60 00 2 00

//--- testbench/tb_clocks_reset.sv
module tb_clocks_reset;

	localparam int frame_bit   = 12;
	localparam int sync_stages = 2;

	logic                     clkin_a;
	logic                     rst_n;
	logic                     ext_reset;
	dmg_clk_pkg::bus_req_t    bus;
	dmg_clk_pkg::data_t       rdata;
	logic                     sys_rst_n;
	logic                     video_rst_n;
	logic                     phi;
	logic                     cpu_ce;
	logic                     cpu_rd_sync;
	dmg_clk_pkg::div_taps_t   taps;
	dmg_clk_pkg::frame_tick_t ticks;

	int     errors = 0;
	int     cycles = 0;
	int     limit  = 200;
	integer seed   = 32'hc80a_6ea0;

	string       op_q[$];
	logic [15:0] addr_q[$];
	logic [7:0]  data_q[$];
	int          wait_q[$];
	logic [7:0]  exp_q[$];

	// divider and frame step model.
	dmg_clk_pkg::div_t div_model;
	logic              fast_model;
	logic              lcd_model;
	logic              fall_last;
	logic              tick_due;
	logic [2:0]        step_count;
	logic [2:0]        fall_step;
	logic [2:0]        due_step;

	clocks_reset #(
		.frame_bit   (frame_bit),
		.sync_stages (sync_stages)
	) dut (
		.clkin_a     (clkin_a),
		.rst_n       (rst_n),
		.ext_reset   (ext_reset),
		.bus         (bus),
		.rdata       (rdata),
		.sys_rst_n   (sys_rst_n),
		.video_rst_n (video_rst_n),
		.phi         (phi),
		.cpu_ce      (cpu_ce),
		.cpu_rd_sync (cpu_rd_sync),
		.taps        (taps),
		.ticks       (ticks)
	);

	initial begin
		clkin_a = 1'b0;
		forever #10 clkin_a = ~clkin_a;
	end

	always @(posedge clkin_a) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			errors++;
			$display("mismatch at %0t: %s (got %0h, expected %0h)", $time, msg, actual,
				expected);
		end
	endtask

	// one clock edge, then the drive point 2 units later.
	task automatic next_cycle;
		logic              run;
		dmg_clk_pkg::div_t next_div;
		run = sys_rst_n;
		@(posedge clkin_a);
		tick_due = fall_last; // tick shows one cycle after the fall.
		due_step = fall_step;
		next_div = div_model;
		if (run && bus.wr && bus.addr == dmg_clk_pkg::addr_div) begin
			next_div = '0;
		end else if (run) begin
			next_div = div_model + (fast_model ? 16'd256 : 16'd1);
		end
		fall_last = run && div_model[frame_bit] && !next_div[frame_bit];
		fall_step = step_count;
		if (!run) begin
			step_count = 3'd0;
		end else if (fall_last) begin
			step_count = step_count + 3'd1;
		end
		div_model = next_div;
		if (run && bus.wr && bus.addr == dmg_clk_pkg::addr_test) fast_model = bus.wdata[1];
		#2;
		// 16384, 65536 and 262144 hz at the master rate.
		compare(taps, {div_model[7], div_model[5], div_model[3]}, "divider taps");
	endtask

	task automatic idle_cycles(input int n);
		bus.wr = 1'b0;
		bus.rd = 1'b0;
		repeat (n) next_cycle();
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data, input int n);
		bus.addr  = addr;
		bus.wdata = data;
		bus.wr    = 1'b1;
		bus.rd    = 1'b0;
		next_cycle();
		bus.wr = 1'b0;
		if (addr == dmg_clk_pkg::addr_lcdc) begin
			compare(video_rst_n, lcd_model, "video_rst_n in the write cycle");
			lcd_model = data[7];
			next_cycle();
			compare(video_rst_n, lcd_model, "video_rst_n one cycle after lcdc write");
		end
		idle_cycles(n);
	endtask

	task automatic bus_read(input logic [15:0] addr, input logic [7:0] expv, input int n);
		logic [7:0] div_byte;
		bus.addr = addr;
		bus.rd   = 1'b1;
		bus.wr   = 1'b0;
		div_byte = div_model[15:8];
		next_cycle();
		bus.rd = 1'b0;
		compare(rdata, expv, $sformatf("read of %h", addr));
		if (addr == dmg_clk_pkg::addr_div) begin
			compare(rdata, div_byte, "ff04 read against divider model");
		end
		idle_cycles(n);
	endtask

	task automatic count_ticks(input int n, input int steps);
		int n512 = 0;
		int n256 = 0;
		int n128 = 0;
		int e512 = 0;
		int e256 = 0;
		int e128 = 0;
		repeat (n) begin
			n512 += ticks.tick_512;
			n256 += ticks.tick_256;
			n128 += ticks.tick_128;
			if (tick_due) begin
				e512++;
				if (!due_step[0]) e256++;
				if (due_step[1:0] == 2'b10) e128++; // steps 2 and 6.
			end
			next_cycle();
		end
		compare(n512, e512, "tick_512 count against step model");
		compare(n256, e256, "tick_256 count against step model");
		compare(n128, e128, "tick_128 count against step model");
		compare(n512, steps, "tick_512 count");
		compare(n256, steps / 2, "tick_256 count");
		compare(n128, steps / 4, "tick_128 count");
	endtask

	task automatic check_reset_release;
		int   n = 0;
		logic ce_prev;
		ce_prev = cpu_ce;
		while (!sys_rst_n && n < sync_stages + 4) begin
			ce_prev = cpu_ce;
			next_cycle();
			n++;
		end
		compare(sys_rst_n, 1'b1, "sys_rst_n within sync_stages + 4 cycles");
		compare(ce_prev, 1'b1, "cpu_ce in the cycle before sys_rst_n rose");
		compare(video_rst_n, 1'b0, "video_rst_n with lcd off");
	endtask

	task automatic check_phases;
		int   ce_count  = 0;
		int   phi_count = 0;
		int   last_ce   = -1;
		logic phi_prev;
		bus.addr = 16'h0000;
		bus.rd   = 1'b1; // rd held high across the window.
		phi_prev = phi;
		next_cycle();
		for (int t = 0; t < 16; t++) begin
			compare(cpu_rd_sync, phi_prev, "cpu_rd_sync follows phi");
			if (cpu_ce) begin
				if (last_ce >= 0) compare(t - last_ce, 4, "cpu_ce spacing");
				last_ce = t;
				ce_count++;
			end
			phi_count += phi;
			phi_prev = phi;
			next_cycle();
		end
		bus.rd = 1'b0;
		compare(ce_count, 4, "cpu_ce pulses in 16 cycles");
		compare(phi_count, 8, "phi high cycles in 16 cycles");
	endtask

	task automatic load_commands(output bit ok);
		integer      fd;
		int          n;
		int          total = 0;
		int          wait_n;
		string       line;
		string       op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  expv;
		fd = $fopen("testbench/clocks_reset_input.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) > 0) begin
					n = $sscanf(line, "%s %h %h %d %h", op, addr, data, wait_n, expv);
					if (n == 5) begin // comment lines fail to parse.
						op_q.push_back(op);
						addr_q.push_back(addr);
						data_q.push_back(data);
						wait_q.push_back(wait_n);
						exp_q.push_back(expv);
						total += wait_n;
					end
				end
			end
			$fclose(fd);
			limit = 2 * total + 200;
		end
	endtask

	task automatic run_commands;
		int gap;
		for (int i = 0; i < op_q.size(); i++) begin
			gap = $random(seed) & 32'h3;
			idle_cycles(gap);
			case (op_q[i])
				"W":     bus_write(addr_q[i], data_q[i], wait_q[i]);
				"R":     bus_read(addr_q[i], exp_q[i], wait_q[i]);
				"WAIT":  idle_cycles(wait_q[i]);
				"TICKS": count_ticks(wait_q[i], exp_q[i]);
				default: begin
					errors++;
					$display("unknown command %s on entry %0d", op_q[i], i);
				end
			endcase
		end
	endtask

	initial begin
		bit ok;
		rst_n      = 1'b0;
		ext_reset  = 1'b0;
		bus        = '0;
		div_model  = '0;
		fast_model = 1'b0;
		lcd_model  = 1'b0;
		fall_last  = 1'b0;
		tick_due   = 1'b0;
		step_count = 3'd0;
		fall_step  = 3'd0;
		due_step   = 3'd0;
		load_commands(ok);
		if (!ok) begin
			$display("could not open the command file testbench/clocks_reset_input.txt");
			$display("Finished with errors");
			$finish;
		end else begin
			repeat (10) @(posedge clkin_a);
			#2;
			compare(cpu_ce, 1'b0, "cpu_ce in reset");
			compare(cpu_rd_sync, 1'b0, "cpu_rd_sync in reset");
			compare(ticks, 3'b000, "ticks in reset");
			compare(sys_rst_n, 1'b0, "sys_rst_n in reset");
			compare(video_rst_n, 1'b0, "video_rst_n in reset");
			compare(rdata, 8'h00, "rdata in reset");
			rst_n = 1'b1;
			check_reset_release();
			check_phases();
			run_commands();
			idle_cycles(4);
			$display("error count: %0d", errors);
			if (errors == 0) begin
				$display("Finished with no errors");
			end else begin
				$display("Finished with errors");
			end
			$finish;
		end
	end

endmodule
